// ==== hdl/retro_pkg.sv ====
`default_nettype none

package retro_pkg;

    // ------------------------------------------------------------------
    // CPU bus and memory map
    // ------------------------------------------------------------------

    localparam int addr_w = 16;
    localparam int mem_aw = 14;

    // Region limits, ROM then RAM then unmapped
    localparam logic [addr_w-1:0] rom_base = 16'h0000;
    localparam logic [addr_w-1:0] ram_base = 16'h4000;
    localparam logic [addr_w-1:0] ram_end  = 16'h8000;

    // Read value when nothing answers
    localparam logic [7:0] open_bus = 8'hFF;

    typedef enum logic [1:0] {
        region_rom,
        region_ram,
        region_none
    } region_t;

    // I/O ports
    localparam logic [addr_w-1:0] port_border_addr = 16'h00FE;
    localparam logic [addr_w-1:0] port_led_addr    = 16'h00FD;

    // ------------------------------------------------------------------
    // VGA 640x480 timing, in pixels and lines
    // ------------------------------------------------------------------

    localparam int h_visible = 640;
    localparam int h_front   = 16;
    localparam int h_sync    = 96;
    localparam int h_back    = 48;

    localparam int v_visible = 480;
    localparam int v_front   = 10;
    localparam int v_sync    = 2;
    localparam int v_back    = 33;

    // Doubled 256x192 bitmap, centred
    localparam int pic_left = 64;
    localparam int pic_top  = 48;
    localparam int pic_w    = 512;
    localparam int pic_h    = 384;

    // Clocks per CPU cycle and per pixel
    localparam int cpu_div = 4;

endpackage

`default_nettype wire

// ==== hdl/boot_rom.sv ====
`timescale 1ns/1ps
`default_nettype none

module boot_rom (
    input  wire                          clock_100,
    input  wire [retro_pkg::mem_aw-1:0]  addr,
    output logic [7:0]                   q
);

    logic [7:0] mem [0:(1 << retro_pkg::mem_aw)-1];

    // Unlisted locations read as zero
    initial begin
        for (int i = 0; i < (1 << retro_pkg::mem_aw); i++) begin
            mem[i] = 8'h00;
        end
        $readmemh("rom_image.hex", mem);
    end

    // One clock of read latency
    always_ff @(posedge clock_100) begin
        q <= mem[addr];
    end

endmodule

`default_nettype wire

// ==== hdl/video_ram.sv ====
`timescale 1ns/1ps
`default_nettype none

module video_ram (
    input  wire                          clock_100,

    // CPU side, read and write
    input  wire [retro_pkg::mem_aw-1:0]  addr_a,
    input  wire [7:0]                    wdata_a,
    input  wire                          we_a,
    output logic [7:0]                   q_a,

    // Video side, read only
    input  wire [retro_pkg::mem_aw-1:0]  addr_b,
    output logic [7:0]                   q_b
);

    logic [7:0] mem [0:(1 << retro_pkg::mem_aw)-1];

    // Port A, old data comes out on a write
    always_ff @(posedge clock_100) begin
        if (we_a) begin
            mem[addr_a] <= wdata_a;
        end
        q_a <= mem[addr_a];
    end

    // Port B for the scanner
    always_ff @(posedge clock_100) begin
        q_b <= mem[addr_b];
    end

endmodule

`default_nettype wire

// ==== hdl/mem_map.sv ====
`timescale 1ns/1ps
`default_nettype none

module mem_map (
    input  wire                          clock_100,
    input  wire                          rst_n,
    input  wire [retro_pkg::addr_w-1:0]  cpu_addr,
    input  wire [7:0]                    cpu_wdata,
    input  wire                          cpu_wr,
    output logic                         cpu_ce,
    output logic                         pix_ce,
    output logic [7:0]                   cpu_rdata,
    output logic [retro_pkg::mem_aw-1:0] mem_addr,
    output logic [7:0]                   ram_wdata,
    output logic                         ram_we,
    input  wire [7:0]                    rom_q,
    input  wire [7:0]                    ram_q
);

    // ------------------------------------------------------------------
    // Phase counter in place of the divided PLL clock
    // ------------------------------------------------------------------

    logic [1:0]         phase;
    retro_pkg::region_t region;

    // Enables and write strobe, one clock after the phase they decode
    always_ff @(posedge clock_100 or negedge rst_n) begin
        if (!rst_n) begin
            phase  <= 2'd0;
            cpu_ce <= 1'b0;
            pix_ce <= 1'b0;
            ram_we <= 1'b0;
        end else begin
            phase  <= phase + 2'd1;
            // High while phase is 3
            cpu_ce <= (phase == 2'(retro_pkg::cpu_div - 2));
            // High while phase is 0
            pix_ce <= (phase == 2'(retro_pkg::cpu_div - 1));
            // One write per CPU cycle, during phase 1, RAM only
            ram_we <= (phase == 2'd0) && cpu_wr && (region == retro_pkg::region_ram);
        end
    end

    // ------------------------------------------------------------------
    // Address decode and read mux
    // ------------------------------------------------------------------

    always_comb begin
        if (cpu_addr[15:14] == retro_pkg::rom_base[15:14]) begin
            region = retro_pkg::region_rom;
        end else if (cpu_addr >= retro_pkg::ram_base && cpu_addr < retro_pkg::ram_end) begin
            region = retro_pkg::region_ram;
        end else begin
            region = retro_pkg::region_none;
        end
    end

    // Shared address for both arrays
    assign mem_addr  = cpu_addr[retro_pkg::mem_aw-1:0];
    assign ram_wdata = cpu_wdata;

    always_comb begin
        case (region)
            retro_pkg::region_rom: cpu_rdata = rom_q;
            retro_pkg::region_ram: cpu_rdata = ram_q;
            default:               cpu_rdata = retro_pkg::open_bus;
        endcase
    end

endmodule

`default_nettype wire

// ==== hdl/io_ports.sv ====
`timescale 1ns/1ps
`default_nettype none

module io_ports (
    input  wire                          clock_100,
    input  wire                          rst_n,
    input  wire                          cpu_ce,
    input  wire [retro_pkg::addr_w-1:0]  port_addr,
    input  wire [7:0]                    port_wdata,
    input  wire                          port_wr,
    input  wire [1:0]                    keys,
    output logic [7:0]                   port_rdata,
    output logic [2:0]                   border,
    output logic [3:0]                   led
);

    // Writes land at the end of the CPU cycle
    always_ff @(posedge clock_100 or negedge rst_n) begin
        if (!rst_n) begin
            border <= 3'd0;
            led    <= 4'd0;
        end else if (cpu_ce && port_wr) begin
            if (port_addr == retro_pkg::port_border_addr) begin
                border <= port_wdata[2:0];
            end
            if (port_addr == retro_pkg::port_led_addr) begin
                led <= port_wdata[3:0];
            end
        end
    end

    // Readback, keys are active low on the board
    always_comb begin
        if (port_addr == retro_pkg::port_border_addr) begin
            port_rdata = {3'b000, border, ~keys};
        end else if (port_addr == retro_pkg::port_led_addr) begin
            port_rdata = {4'b0000, led};
        end else begin
            port_rdata = 8'hFF;
        end
    end

endmodule

`default_nettype wire

// ==== hdl/vga_scan.sv ====
`timescale 1ns/1ps
`default_nettype none

module vga_scan (
    input  wire                          clock_100,
    input  wire                          rst_n,
    input  wire                          pix_ce,
    input  wire [7:0]                    vid_data,
    input  wire [2:0]                    border,
    output logic [retro_pkg::mem_aw-1:0] vid_addr,
    output logic [4:0]                   vga_red,
    output logic [5:0]                   vga_green,
    output logic [4:0]                   vga_blue,
    output logic                         vga_hs,
    output logic                         vga_vs
);

    // Counter 0 is the first pixel of sync
    localparam logic [9:0] h_active = 10'(retro_pkg::h_sync + retro_pkg::h_back);
    localparam logic [9:0] h_total  = 10'(retro_pkg::h_visible + retro_pkg::h_front
                                          + retro_pkg::h_sync + retro_pkg::h_back);
    localparam logic [9:0] v_active = 10'(retro_pkg::v_sync + retro_pkg::v_back);
    localparam logic [9:0] v_total  = 10'(retro_pkg::v_visible + retro_pkg::v_front
                                          + retro_pkg::v_sync + retro_pkg::v_back);
    localparam logic [9:0] pic_x0   = h_active + 10'(retro_pkg::pic_left);
    localparam logic [9:0] pic_y0   = v_active + 10'(retro_pkg::pic_top);

    logic [9:0] h_cnt;
    logic [9:0] v_cnt;
    logic [9:0] fetch_col;
    logic [9:0] pic_line;
    logic [7:0] shifter;
    logic       in_vis;
    logic       in_pic;

    // ------------------------------------------------------------------
    // Counters and bitmap fetch
    // ------------------------------------------------------------------

    // Runs one pixel ahead of the picture column
    assign fetch_col = h_cnt - pic_x0 + 10'd1;
    assign pic_line  = v_cnt - pic_y0;

    // Row of 32 bytes, one byte per 16 output pixels
    assign vid_addr  = {1'b0, pic_line[8:1], fetch_col[8:4]};

    assign in_vis = (h_cnt >= h_active) && (h_cnt < h_active + 10'(retro_pkg::h_visible))
                 && (v_cnt >= v_active) && (v_cnt < v_active + 10'(retro_pkg::v_visible));
    assign in_pic = (h_cnt >= pic_x0) && (h_cnt < pic_x0 + 10'(retro_pkg::pic_w))
                 && (v_cnt >= pic_y0) && (v_cnt < pic_y0 + 10'(retro_pkg::pic_h));

    always_ff @(posedge clock_100 or negedge rst_n) begin
        if (!rst_n) begin
            h_cnt <= 10'd0;
            v_cnt <= 10'd0;
        end else if (pix_ce) begin
            if (h_cnt == h_total - 10'd1) begin
                h_cnt <= 10'd0;
                v_cnt <= (v_cnt == v_total - 10'd1) ? 10'd0 : v_cnt + 10'd1;
            end else begin
                h_cnt <= h_cnt + 10'd1;
            end
        end
    end

    // Load on the last pixel of a group, shift every second pixel
    always_ff @(posedge clock_100) begin
        if (pix_ce && !fetch_col[0]) begin
            if (fetch_col[3:0] == 4'd0) begin
                shifter <= vid_data;
            end else begin
                shifter <= {shifter[6:0], 1'b0};
            end
        end
    end

    // ------------------------------------------------------------------
    // Syncs and colour, same latency so they stay aligned
    // ------------------------------------------------------------------

    always_ff @(posedge clock_100 or negedge rst_n) begin
        if (!rst_n) begin
            vga_hs    <= 1'b1;
            vga_vs    <= 1'b1;
            vga_red   <= 5'd0;
            vga_green <= 6'd0;
            vga_blue  <= 5'd0;
        end else if (pix_ce) begin
            vga_hs <= !(h_cnt < 10'(retro_pkg::h_sync));
            vga_vs <= !(v_cnt < 10'(retro_pkg::v_sync));
            if (!in_vis) begin
                vga_red   <= 5'd0;
                vga_green <= 6'd0;
                vga_blue  <= 5'd0;
            end else if (in_pic) begin
                // MSB is the leftmost pixel
                vga_red   <= {5{shifter[7]}};
                vga_green <= {6{shifter[7]}};
                vga_blue  <= {5{shifter[7]}};
            end else begin
                vga_red   <= {5{border[2]}};
                vga_green <= {6{border[1]}};
                vga_blue  <= {5{border[0]}};
            end
        end
    end

endmodule

`default_nettype wire

// ==== hdl/retro_soc.sv ====
`timescale 1ns/1ps
`default_nettype none

module retro_soc (
    input  wire                          clock_100,
    input  wire                          rst_n,
    input  wire [1:0]                    keys,

    // CPU bus
    input  wire [retro_pkg::addr_w-1:0]  cpu_addr,
    input  wire [7:0]                    cpu_wdata,
    input  wire                          cpu_wr,
    output wire                          cpu_ce,
    output wire [7:0]                    cpu_rdata,

    // Port bus
    input  wire [retro_pkg::addr_w-1:0]  port_addr,
    input  wire [7:0]                    port_wdata,
    input  wire                          port_wr,
    output wire [7:0]                    port_rdata,

    output wire [3:0]                    led,

    // VGA
    output wire [4:0]                    vga_red,
    output wire [5:0]                    vga_green,
    output wire [4:0]                    vga_blue,
    output wire                          vga_hs,
    output wire                          vga_vs
);

    // ------------------------------------------------------------------
    // Internal nets
    // ------------------------------------------------------------------

    wire                          pix_ce;
    wire [retro_pkg::mem_aw-1:0]  mem_addr;
    wire [7:0]                    ram_wdata;
    wire                          ram_we;
    wire [7:0]                    rom_q;
    wire [7:0]                    ram_q;
    wire [retro_pkg::mem_aw-1:0]  vid_addr;
    wire [7:0]                    vid_data;
    wire [2:0]                    border;

    // Clock enables, decode and read mux
    mem_map mem_map_i (
        .clock_100 (clock_100),
        .rst_n     (rst_n),
        .cpu_addr  (cpu_addr),
        .cpu_wdata (cpu_wdata),
        .cpu_wr    (cpu_wr),
        .cpu_ce    (cpu_ce),
        .pix_ce    (pix_ce),
        .cpu_rdata (cpu_rdata),
        .mem_addr  (mem_addr),
        .ram_wdata (ram_wdata),
        .ram_we    (ram_we),
        .rom_q     (rom_q),
        .ram_q     (ram_q)
    );

    // 0x0000 to 0x3FFF
    boot_rom boot_rom_i (
        .clock_100 (clock_100),
        .addr      (mem_addr),
        .q         (rom_q)
    );

    // 0x4000 to 0x7FFF, bitmap at the bottom
    video_ram video_ram_i (
        .clock_100 (clock_100),
        .addr_a    (mem_addr),
        .wdata_a   (ram_wdata),
        .we_a      (ram_we),
        .q_a       (ram_q),
        .addr_b    (vid_addr),
        .q_b       (vid_data)
    );

    io_ports io_ports_i (
        .clock_100  (clock_100),
        .rst_n      (rst_n),
        .cpu_ce     (cpu_ce),
        .port_addr  (port_addr),
        .port_wdata (port_wdata),
        .port_wr    (port_wr),
        .keys       (keys),
        .port_rdata (port_rdata),
        .border     (border),
        .led        (led)
    );

    vga_scan vga_scan_i (
        .clock_100 (clock_100),
        .rst_n     (rst_n),
        .pix_ce    (pix_ce),
        .vid_data  (vid_data),
        .border    (border),
        .vid_addr  (vid_addr),
        .vga_red   (vga_red),
        .vga_green (vga_green),
        .vga_blue  (vga_blue),
        .vga_hs    (vga_hs),
        .vga_vs    (vga_vs)
    );

endmodule

`default_nettype wire

// ==== tests/tb_clock.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_clock (
    output logic clock_100
);

    // 20 ns period
    localparam int half_period = 10;

    initial begin
        clock_100 = 1'b0;
        forever #(half_period) clock_100 = ~clock_100;
    end

endmodule

`default_nettype wire

// ==== tests/retro_soc_asserts.sv ====
`timescale 1ns/1ps
`default_nettype none

module retro_soc_asserts (
    input  wire        clock_100,
    input  wire        rst_n,
    input  wire        cpu_ce,
    input  wire        ram_we,
    input  wire [15:0] cpu_addr,
    input  wire        vga_hs
);

    localparam int hs_low_clocks = retro_pkg::h_sync * retro_pkg::cpu_div;

    // Failed assertions so far
    int fail_count = 0;

    logic [15:0] hs_low_count;

    // Clocks spent with hs low
    always_ff @(posedge clock_100 or negedge rst_n) begin
        if (!rst_n) begin
            hs_low_count <= 16'd0;
        end else if (!vga_hs) begin
            hs_low_count <= hs_low_count + 16'd1;
        end else begin
            hs_low_count <= 16'd0;
        end
    end

    // One cpu_ce pulse every 4 clocks
    ce_period: assert property (@(posedge clock_100) disable iff (!rst_n)
        cpu_ce |=> !cpu_ce ##1 !cpu_ce ##1 !cpu_ce ##1 cpu_ce)
    else begin
        $error("cpu_ce does not repeat every 4 clocks");
        fail_count++;
    end

    // Single clock strobe, RAM window only
    we_single: assert property (@(posedge clock_100) disable iff (!rst_n)
        ram_we |=> !ram_we)
    else begin
        $error("ram_we high for more than one clock");
        fail_count++;
    end

    we_region: assert property (@(posedge clock_100) disable iff (!rst_n)
        ram_we |-> (cpu_addr >= retro_pkg::ram_base && cpu_addr < retro_pkg::ram_end))
    else begin
        $error("ram_we outside the RAM region");
        fail_count++;
    end

    hs_width: assert property (@(posedge clock_100) disable iff (!rst_n)
        $rose(vga_hs) |-> (hs_low_count == 16'(hs_low_clocks)))
    else begin
        $error("vga_hs low time is not h_sync pixel periods");
        fail_count++;
    end

endmodule

bind retro_soc retro_soc_asserts asserts_i (
    .clock_100 (clock_100),
    .rst_n     (rst_n),
    .cpu_ce    (cpu_ce),
    .ram_we    (ram_we),
    .cpu_addr  (cpu_addr),
    .vga_hs    (vga_hs)
);

`default_nettype wire

// ==== tests/tb_retro_soc.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_retro_soc;

    // ------------------------------------------------------------------
    // Test lengths and run limit
    // ------------------------------------------------------------------

    localparam int drive_delay  = 2;
    localparam int n_rom        = 200;
    localparam int n_ram        = 400;
    localparam int n_open       = 100;
    localparam int n_port       = 200;
    localparam int bitmap_bytes = (retro_pkg::pic_w / 2) * (retro_pkg::pic_h / 2) / 8;
    localparam int h_total = retro_pkg::h_visible + retro_pkg::h_front
                           + retro_pkg::h_sync + retro_pkg::h_back;
    localparam int v_total = retro_pkg::v_visible + retro_pkg::v_front
                           + retro_pkg::v_sync + retro_pkg::v_back;
    localparam int h_start = retro_pkg::h_sync + retro_pkg::h_back;
    localparam int v_start = retro_pkg::v_sync + retro_pkg::v_back;
    localparam int frame_clocks = h_total * v_total * retro_pkg::cpu_div;
    // Worst case bus traffic, with a write before every read
    localparam int bus_cycles = 2 * n_rom + n_ram + 2 * n_open + n_port + bitmap_bytes + 4;
    // Up to one frame to find vs, then one full frame
    localparam int timeout_cycles = 2 * frame_clocks + bus_cycles * retro_pkg::cpu_div + 1000;

    wire         clock_100;
    logic        rst_n;
    logic [1:0]  keys;
    logic [15:0] cpu_addr;
    logic [7:0]  cpu_wdata;
    logic        cpu_wr;
    logic [15:0] port_addr;
    logic [7:0]  port_wdata;
    logic        port_wr;
    wire         cpu_ce;
    wire  [7:0]  cpu_rdata;
    wire  [7:0]  port_rdata;
    wire  [3:0]  led;
    wire  [4:0]  vga_red;
    wire  [5:0]  vga_green;
    wire  [4:0]  vga_blue;
    wire         vga_hs;
    wire         vga_vs;

    // Models
    logic [7:0] rom_model [0:16383];
    logic [7:0] ram_model [0:16383];
    logic [2:0] border_model;
    logic [3:0] led_model;
    int         cycle_count = 0;

    tb_clock tb_clock_i (.clock_100(clock_100));

    retro_soc retro_soc_i (
        .clock_100  (clock_100),
        .rst_n      (rst_n),
        .keys       (keys),
        .cpu_addr   (cpu_addr),
        .cpu_wdata  (cpu_wdata),
        .cpu_wr     (cpu_wr),
        .cpu_ce     (cpu_ce),
        .cpu_rdata  (cpu_rdata),
        .port_addr  (port_addr),
        .port_wdata (port_wdata),
        .port_wr    (port_wr),
        .port_rdata (port_rdata),
        .led        (led),
        .vga_red    (vga_red),
        .vga_green  (vga_green),
        .vga_blue   (vga_blue),
        .vga_hs     (vga_hs),
        .vga_vs     (vga_vs)
    );

    always @(posedge clock_100) cycle_count <= cycle_count + 1;

    initial begin
        wait (cycle_count >= timeout_cycles);
        $display("Timeout after %0d clock cycles without a result", cycle_count);
        $display("Finished with errors");
        $fatal(1);
    end

    task automatic fail_now(input string what);
        $display("%s", what);
        $display("Finished with errors");
        $fatal(1);
    endtask

    // ------------------------------------------------------------------
    // Bus cycles
    // ------------------------------------------------------------------

    // Middle of phase 3, stable for data and pixels
    task automatic wait_ce_high();
        @(negedge clock_100);
        while (!cpu_ce) @(negedge clock_100);
    endtask

    // Sample while cpu_ce is high, then step past the cycle end
    task automatic finish_cycle(output logic [7:0] cpu_rd, output logic [7:0] port_rd);
        wait_ce_high();
        cpu_rd  = cpu_rdata;
        port_rd = port_rdata;
        @(posedge clock_100);
        #(drive_delay);
    endtask

    task automatic cpu_write(input logic [15:0] addr, input logic [7:0] data);
        logic [7:0] cpu_rd;
        logic [7:0] port_rd;
        cpu_addr  = addr;
        cpu_wdata = data;
        cpu_wr    = 1'b1;
        finish_cycle(cpu_rd, port_rd);
        cpu_wr    = 1'b0;
    endtask

    task automatic cpu_read(input logic [15:0] addr, output logic [7:0] data);
        logic [7:0] port_rd;
        cpu_addr = addr;
        cpu_wr   = 1'b0;
        finish_cycle(data, port_rd);
    endtask

    task automatic port_write(input logic [15:0] addr, input logic [7:0] data);
        logic [7:0] cpu_rd;
        logic [7:0] port_rd;
        port_addr  = addr;
        port_wdata = data;
        port_wr    = 1'b1;
        finish_cycle(cpu_rd, port_rd);
        port_wr    = 1'b0;
    endtask

    task automatic port_read(input logic [15:0] addr, input logic [1:0] k,
                             output logic [7:0] data);
        logic [7:0] cpu_rd;
        port_addr = addr;
        keys      = k;
        finish_cycle(cpu_rd, data);
    endtask

    // ------------------------------------------------------------------
    // Reference rules
    // ------------------------------------------------------------------

    // Keys read back inverted under the border bits
    function automatic logic [7:0] port_expect(input logic [15:0] addr, input logic [1:0] k);
        if (addr == retro_pkg::port_border_addr) begin
            port_expect = {3'b000, border_model, ~k};
        end else if (addr == retro_pkg::port_led_addr) begin
            port_expect = {4'h0, led_model};
        end else begin
            port_expect = 8'hFF;
        end
    endfunction

    // Packed as red, green, blue for one visible pixel
    function automatic logic [15:0] colour_at(input int x, input int y);
        int         idx;
        logic [7:0] pixels;
        if (x >= retro_pkg::pic_left && x < retro_pkg::pic_left + retro_pkg::pic_w
            && y >= retro_pkg::pic_top && y < retro_pkg::pic_top + retro_pkg::pic_h) begin
            // Bitmap pixels are doubled both ways
            idx    = ((y - retro_pkg::pic_top) / 2) * 32 + (x - retro_pkg::pic_left) / 16;
            pixels = ram_model[14'(idx)];
            if (pixels[3'(7 - ((x - retro_pkg::pic_left) % 16) / 2)]) begin
                colour_at = 16'hFFFF;
            end else begin
                colour_at = 16'h0000;
            end
        end else begin
            colour_at = {{5{border_model[2]}}, {6{border_model[1]}}, {5{border_model[0]}}};
        end
    endfunction

    // ------------------------------------------------------------------
    // Tests
    // ------------------------------------------------------------------

    task automatic test_rom();
        logic [15:0] addr;
        logic [7:0]  got;
        for (int i = 0; i < n_rom; i++) begin
            // Half inside the image, half anywhere
            if ($urandom_range(0, 1) == 1) begin
                addr = 16'($urandom_range(0, 255));
            end else begin
                addr = 16'($urandom_range(0, 16'h3FFF));
            end
            // ROM ignores writes, the read below sees the image byte
            if ($urandom_range(0, 3) == 0) begin
                cpu_write(addr, 8'($urandom));
            end
            cpu_read(addr, got);
            assert (got == rom_model[addr[13:0]])
            else fail_now($sformatf("[ERROR] cpu_rdata at %h: got %h expected %h",
                                    addr, got, rom_model[addr[13:0]]));
        end
    endtask

    task automatic test_ram();
        logic [13:0] off;
        logic [7:0]  data;
        logic [7:0]  got;
        logic [13:0] written_q[$];
        for (int i = 0; i < n_ram; i++) begin
            if (written_q.size() == 0 || $urandom_range(0, 1) == 1) begin
                // Some writes overwrite a known location
                if (written_q.size() != 0 && $urandom_range(0, 1) == 1) begin
                    off = written_q[$urandom_range(0, written_q.size() - 1)];
                end else begin
                    off = 14'($urandom);
                    written_q.push_back(off);
                end
                data = 8'($urandom);
                cpu_write(retro_pkg::ram_base + {2'b00, off}, data);
                ram_model[off] = data;
            end else begin
                off = written_q[$urandom_range(0, written_q.size() - 1)];
                cpu_read(retro_pkg::ram_base + {2'b00, off}, got);
                assert (got == ram_model[off])
                else fail_now($sformatf("[ERROR] cpu_rdata at %h: got %h expected %h",
                                        retro_pkg::ram_base + {2'b00, off}, got, ram_model[off]));
            end
        end
    endtask

    task automatic test_open_bus();
        logic [15:0] addr;
        logic [7:0]  got;
        for (int i = 0; i < n_open; i++) begin
            addr = retro_pkg::ram_end | 16'($urandom);
            if ($urandom_range(0, 1) == 1) begin
                cpu_write(addr, 8'($urandom));
            end
            cpu_read(addr, got);
            assert (got == retro_pkg::open_bus)
            else fail_now($sformatf("[ERROR] cpu_rdata at %h: got %h expected %h",
                                    addr, got, retro_pkg::open_bus));
        end
    endtask

    task automatic test_ports();
        int          sel;
        logic [15:0] addr;
        logic [7:0]  data;
        logic [7:0]  got;
        logic [1:0]  k;
        for (int i = 0; i < n_port; i++) begin
            sel  = int'($urandom_range(0, 2));
            addr = (sel == 0) ? retro_pkg::port_border_addr
                 : (sel == 1) ? retro_pkg::port_led_addr : 16'($urandom);
            data = 8'($urandom);
            if ($urandom_range(0, 1) == 1) begin
                port_write(addr, data);
                if (addr == retro_pkg::port_border_addr) border_model = data[2:0];
                if (addr == retro_pkg::port_led_addr) led_model = data[3:0];
                assert (led == led_model)
                else fail_now($sformatf("[ERROR] led: got %h expected %h", led, led_model));
            end else begin
                k = 2'($urandom);
                port_read(addr, k, got);
                assert (got == port_expect(addr, k))
                else fail_now($sformatf("[ERROR] port_rdata at %h: got %h expected %h",
                                        addr, got, port_expect(addr, k)));
            end
        end
    endtask

    // Picture lines, border rows and all blanking are compared
    task automatic check_pixel(input int line, input int px);
        int          x;
        int          y;
        logic        vis;
        logic [15:0] got;
        logic [15:0] exp;
        x   = px - h_start;
        y   = line - v_start;
        vis = (x >= 0 && x < retro_pkg::h_visible && y >= 0 && y < retro_pkg::v_visible);
        got = {vga_red, vga_green, vga_blue};
        exp = vis ? colour_at(x, y) : 16'h0000;
        if (!vis || y == 0 || y == 400
            || (y >= retro_pkg::pic_top && y <= retro_pkg::pic_top + 3)) begin
            assert (got == exp)
            else fail_now($sformatf("[ERROR] vga colour at line %0d pixel %0d: got %h expected %h",
                                    line, px, got, exp));
        end
    endtask

    task automatic check_frame();
        logic prev_hs;
        logic prev_vs;
        logic hs_fell;
        logic vs_fell;
        int   line;
        int   px;
        int   hs_falls;
        logic done;
        // Find the frame start
        vs_fell = 1'b0;
        while (!vs_fell) begin
            prev_vs = vga_vs;
            wait_ce_high();
            vs_fell = prev_vs && !vga_vs;
        end
        line     = 0;
        px       = 0;
        hs_falls = 1;
        done     = 1'b0;
        check_pixel(line, px);
        while (!done) begin
            prev_hs = vga_hs;
            prev_vs = vga_vs;
            wait_ce_high();
            hs_fell = prev_hs && !vga_hs;
            vs_fell = prev_vs && !vga_vs;
            if (hs_fell) begin
                assert (px + 1 == h_total)
                else fail_now($sformatf("[ERROR] pixel periods per line: got %h expected %h",
                                        px + 1, h_total));
                px = 0;
                if (vs_fell) begin
                    done = 1'b1;
                end else begin
                    line++;
                    hs_falls++;
                end
            end else begin
                px++;
            end
            if (!done) check_pixel(line, px);
        end
        assert (hs_falls == v_total)
        else fail_now($sformatf("[ERROR] vga_hs falls per frame: got %h expected %h",
                                hs_falls, v_total));
    endtask

    task automatic test_video();
        logic [7:0] data;
        for (int i = 0; i < bitmap_bytes; i++) begin
            data = 8'($urandom);
            cpu_write(retro_pkg::ram_base + 16'(i), data);
            ram_model[14'(i)] = data;
        end
        data = 8'($urandom);
        port_write(retro_pkg::port_border_addr, data);
        border_model = data[2:0];
        check_frame();
    endtask

    // ------------------------------------------------------------------
    // Main sequence
    // ------------------------------------------------------------------

    initial begin
        logic [7:0] cpu_rd;
        logic [7:0] port_rd;
        void'($urandom(62));
        rst_n      = 1'b0;
        keys       = 2'b00;
        cpu_addr   = 16'h0000;
        cpu_wdata  = 8'h00;
        cpu_wr     = 1'b0;
        port_addr  = 16'h0000;
        port_wdata = 8'h00;
        port_wr    = 1'b0;
        border_model = 3'd0;
        led_model    = 4'd0;
        // Same image as the ROM, zero past its end
        for (int i = 0; i < 16384; i++) begin
            rom_model[14'(i)] = 8'h00;
        end
        $readmemh("rom_image.hex", rom_model);
        repeat (10) @(posedge clock_100);
        assert (led == 4'h0)
        else fail_now($sformatf("[ERROR] led in reset: got %h expected %h", led, 4'h0));
        assert (vga_hs && vga_vs)
        else fail_now($sformatf("[ERROR] vga_hs, vga_vs in reset: got %h expected %h",
                                {vga_hs, vga_vs}, 2'b11));
        assert (!cpu_ce)
        else fail_now($sformatf("[ERROR] cpu_ce in reset: got %h expected %h", cpu_ce, 1'b0));
        assert ({vga_red, vga_green, vga_blue} == 16'h0000)
        else fail_now($sformatf("[ERROR] vga colour in reset: got %h expected %h",
                                {vga_red, vga_green, vga_blue}, 16'h0000));
        #(drive_delay);
        rst_n = 1'b1;
        // Line up with the first CPU cycle
        finish_cycle(cpu_rd, port_rd);
        test_rom();
        test_ram();
        test_open_bus();
        test_ports();
        test_video();
        if (retro_soc_i.asserts_i.fail_count == 0) begin
            $display("Finished with no errors");
            $finish;
        end else begin
            fail_now("Bound assertions reported failures");
        end
    end

endmodule

`default_nettype wire

// ==== rom_image.hex ====
// Boot ROM image, one hex byte per entry, 16 bytes per line from address 0000
F3 31 00 80 3E 07 D3 FE 21 00 40 11 01 40 01 FF
17 36 00 ED B0 3E 05 D3 FD CD 40 00 C3 1C 00 00
C9 3A 10 80 B7 28 FA 47 E6 0F 32 11 80 78 0F 0F
0F 0F E6 0F 32 12 80 C9 00 00 00 00 00 00 00 00
21 00 40 06 C0 0E 20 3E AA 77 23 0D 20 FA 2F 10
F5 C9 DB FE E6 03 FE 03 20 F8 3E 02 D3 FE C9 55
01 02 04 08 10 20 40 80 FF 7F 3F 1F 0F 07 03 01
3C 42 81 A5 81 99 42 3C 18 3C 7E FF FF 7E 3C 18
E5 D5 C5 F5 2A 20 80 ED 5B 22 80 19 22 20 80 F1
C1 D1 E1 FB ED 4D 00 00 76 18 FD 00 00 00 00 00
4D 45 4D 20 43 4F 52 45 20 56 31 2E 30 00 0D 0A
52 45 41 44 59 0D 0A 00 3E 0F D3 FD 3E 00 D3 FE
CD 50 00 10 FB 0D 20 F8 C9 11 00 00 1B 7A B3 20
FB C9 06 08 CB 27 30 01 3C 10 F9 C9 9A 5C 37 E1
0F 1E 2D 3C 4B 5A 69 78 87 96 A5 B4 C3 D2 E1 F0
A5 5A C3 3C 96 69 0F F0 12 34 56 78 9A BC DE EF

// ==== compile.f ====
hdl/retro_pkg.sv
hdl/boot_rom.sv
hdl/video_ram.sv
hdl/mem_map.sv
hdl/io_ports.sv
hdl/vga_scan.sv
hdl/retro_soc.sv
tests/tb_clock.sv
tests/retro_soc_asserts.sv
tests/tb_retro_soc.sv

// ==== Makefile ====
VERILATOR := verilator
VFLAGS    := --binary --timing --assert -j 0
TOP       := tb_retro_soc
FILELIST  := compile.f

SOURCES   := $(shell grep -v '^+' $(FILELIST))
BIN       := obj_dir/V$(TOP)
PASS_MSG  := Finished with no errors

.PHONY: all run clean

all: run

$(BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf obj_dir
